// File: design/exec_cluster.sv
// ========================================
// exec_cluster: R and I execution units
// sharing one write port through arbiter
// ========================================
module exec_cluster (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             r_valid,
	input  riscv_pkg::r_op_t r_op,
	output logic             r_credit,
	input  logic             i_valid,
	input  riscv_pkg::i_op_t i_op,
	output logic             i_credit,
	output logic             wb_valid,
	output riscv_pkg::wb_t   wb
);
	import riscv_pkg::*;

	logic req_r;
	logic req_i;
	logic gnt_r;
	logic gnt_i;
	wb_t  result_r;   // Held R result
	wb_t  result_i;   // Held I result

	r_type_alu u_r_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.op_valid (r_valid),
		.op       (r_op),
		.credit   (r_credit),
		.req      (req_r),
		.gnt      (gnt_r),
		.result   (result_r)
	);

	i_type_alu u_i_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.op_valid (i_valid),
		.op       (i_op),
		.credit   (i_credit),
		.req      (req_i),
		.gnt      (gnt_i),
		.result   (result_i)
	);

	// Shared write port
	wb_arbiter u_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.req_r    (req_r),
		.req_i    (req_i),
		.result_r (result_r),
		.result_i (result_i),
		.gnt_r    (gnt_r),
		.gnt_i    (gnt_i),
		.wb_valid (wb_valid),
		.wb       (wb)
	);

endmodule : exec_cluster

// File: design/i_type_alu.sv
// ========================================
// i_type_alu: I-type execution unit with
// immediate decode, queue and held result
// ========================================
module i_type_alu (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             op_valid,
	input  riscv_pkg::i_op_t op,
	output logic             credit,
	output logic             req,
	input  logic             gnt,
	output riscv_pkg::wb_t   result
);
	import riscv_pkg::*;

	i_op_t           head;
	logic            queued;
	logic            load;
	logic            shift_op;
	i_func           func;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] alu_out;

	op_queue #(
		.payload_t(i_op_t)
	) u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (op_valid),
		.push_data (op),
		.pop       (load),
		.head      (head),
		.not_empty (queued)
	);

	assign imm      = {{(xlen-12){head.idata[31]}}, head.idata[31:20]};
	assign shift_op = (head.idata[13:12] == 2'b01);  // funct3 001 or 101
	assign func     = i_func'({head.idata[30] & shift_op, head.idata[14:12]});

	always_comb begin
		case (func)
			i_addi:  alu_out = head.rv1 + imm;
			i_slti:  alu_out = {{(xlen-1){1'b0}}, $signed(head.rv1) < $signed(imm)};
			i_sltiu: alu_out = {{(xlen-1){1'b0}}, head.rv1 < imm};
			i_xori:  alu_out = head.rv1 ^ imm;
			i_ori:   alu_out = head.rv1 | imm;
			i_andi:  alu_out = head.rv1 & imm;
			i_slli:  alu_out = head.rv1 << head.idata[24:20];
			i_srli:  alu_out = head.rv1 >> head.idata[24:20];
			i_srai:  alu_out = $unsigned($signed(head.rv1) >>> head.idata[24:20]);
			default: alu_out = '0;
		endcase
	end

	assign load   = queued && (!req || gnt);
	assign credit = load;

	always_ff @(posedge clk) begin
		if (load)
			result <= '{rd: head.idata[11:7], data: alu_out};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req <= 1'b0;
		else if (load)
			req <= 1'b1;                              // New result waiting
		else if (gnt)
			req <= 1'b0;
	end

endmodule : i_type_alu

// File: design/op_queue.sv
// ========================================
// op_queue: circular operation buffer,
// payload chosen by type parameter
// ========================================
module op_queue #(
	parameter type payload_t = logic [riscv_pkg::xlen-1:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     not_empty
);
	import riscv_pkg::*;

	payload_t            mem [queue_depth];
	logic [qptr_w-1:0]   wr_ptr;
	logic [qptr_w-1:0]   rd_ptr;
	logic [credit_w-1:0] count;

	// Wrap explicitly so a non power of two depth also works
	function automatic logic [qptr_w-1:0] next_ptr(input logic [qptr_w-1:0] p);
		return (p == qptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // Both or neither
			endcase
		end
	end

	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0);

endmodule : op_queue

// File: design/r_type_alu.sv
// ========================================
// r_type_alu: R-type execution unit with
// input queue, credit return, held result
// ========================================
module r_type_alu (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             op_valid,
	input  riscv_pkg::r_op_t op,
	output logic             credit,
	output logic             req,
	input  logic             gnt,
	output riscv_pkg::wb_t   result
);
	import riscv_pkg::*;

	r_op_t           head;
	logic            queued;
	logic            load;
	r_func           func;
	logic [xlen-1:0] alu_out;

	op_queue #(
		.payload_t(r_op_t)
	) u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (op_valid),
		.push_data (op),
		.pop       (load),
		.head      (head),
		.not_empty (queued)
	);

	assign func = r_func'({head.idata[30], head.idata[25], head.idata[14:12]});

	always_comb begin
		case (func)
			r_add:   alu_out = head.rv1 + head.rv2;
			r_sub:   alu_out = head.rv1 - head.rv2;
			r_sll:   alu_out = head.rv1 << head.rv2[4:0];
			r_slt:   alu_out = {{(xlen-1){1'b0}}, $signed(head.rv1) < $signed(head.rv2)};
			r_sltu:  alu_out = {{(xlen-1){1'b0}}, head.rv1 < head.rv2};
			r_xor:   alu_out = head.rv1 ^ head.rv2;
			r_srl:   alu_out = head.rv1 >> head.rv2[4:0];
			r_sra:   alu_out = $unsigned($signed(head.rv1) >>> head.rv2[4:0]);
			r_or:    alu_out = head.rv1 | head.rv2;
			r_and:   alu_out = head.rv1 & head.rv2;
			default: alu_out = '0;                    // Unlisted code
		endcase
	end

	// Refill when the slot is free or being drained this cycle
	assign load   = queued && (!req || gnt);
	assign credit = load;                             // Queue entry freed

	always_ff @(posedge clk) begin
		if (load) begin
			result.rd   <= head.idata[11:7];
			result.data <= alu_out;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req <= 1'b0;
		else if (load)
			req <= 1'b1;
		else if (gnt)
			req <= 1'b0;
	end

endmodule : r_type_alu

// File: design/riscv_pkg.sv
// ========================================
// Shared widths, queue depth, function codes
// and payload structs of the execute cluster
// ========================================
package riscv_pkg;

	localparam int xlen        = 32;
	localparam int queue_depth = 4;                      // Entries per unit queue
	localparam int credit_w    = 3;                      // Holds 0 to queue_depth
	localparam int qptr_w      = $clog2(queue_depth);

	// R-type code is {idata[30], idata[25], funct3}
	typedef enum logic [4:0] {
		r_add  = 5'b0_0_000,
		r_sub  = 5'b1_0_000,
		r_sll  = 5'b0_0_001,
		r_slt  = 5'b0_0_010,
		r_sltu = 5'b0_0_011,
		r_xor  = 5'b0_0_100,
		r_srl  = 5'b0_0_101,
		r_sra  = 5'b1_0_101,
		r_or   = 5'b0_0_110,
		r_and  = 5'b0_0_111
	} r_func;

	// I-type code is {idata[30], funct3}
	// Bit 30 only separates SRAI from SRLI, otherwise it is immediate
	typedef enum logic [3:0] {
		i_addi  = 4'b0_000,
		i_slli  = 4'b0_001,
		i_slti  = 4'b0_010,
		i_sltiu = 4'b0_011,
		i_xori  = 4'b0_100,
		i_srli  = 4'b0_101,
		i_srai  = 4'b1_101,
		i_ori   = 4'b0_110,
		i_andi  = 4'b0_111
	} i_func;

	// Register-register op with both operands already read
	typedef struct packed {
		logic [31:0]     idata;
		logic [xlen-1:0] rv1;
		logic [xlen-1:0] rv2;
	} r_op_t;

	// Immediate op, imm comes out of idata[31:20]
	typedef struct packed {
		logic [31:0]     idata;
		logic [xlen-1:0] rv1;
	} i_op_t;

	// One register file write
	typedef struct packed {
		logic [4:0]      rd;
		logic [xlen-1:0] data;
	} wb_t;

endpackage : riscv_pkg

// File: design/wb_arbiter.sv
// ========================================
// wb_arbiter: round-robin of the two units
// onto the register file write port
// ========================================
module wb_arbiter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           req_r,
	input  logic           req_i,
	input  riscv_pkg::wb_t result_r,
	input  riscv_pkg::wb_t result_i,
	output logic           gnt_r,
	output logic           gnt_i,
	output logic           wb_valid,
	output riscv_pkg::wb_t wb
);

	logic last_i;  // I unit won the last grant

	// R wins alone, or on a tie when I went last
	assign gnt_r = req_r && (!req_i || last_i);
	assign gnt_i = req_i && !gnt_r;

	// Starts as if I went last so R has first priority
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_i <= 1'b1;
		else if (gnt_r)
			last_i <= 1'b0;
		else if (gnt_i)
			last_i <= 1'b1;
	end

	assign wb_valid = gnt_r || gnt_i;
	assign wb       = gnt_i ? result_i : result_r;   // Sink ignores wb when not valid

endmodule : wb_arbiter

// File: sim/exec_cluster_asserts.sv
// ========================================
// Concurrent checks on wb_arbiter grants,
// bound into the arbiter
// ========================================
module wb_arbiter_asserts (
	input logic           clk,
	input logic           rst_n,
	input logic           req_r,
	input logic           req_i,
	input riscv_pkg::wb_t result_r,
	input riscv_pkg::wb_t result_i,
	input logic           gnt_r,
	input logic           gnt_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;  // Failed assertions so far

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt_r && gnt_i))
	else begin
		fail_count++;
		$error("Both units granted in the same cycle");
	end

	a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		(!gnt_r || req_r) && (!gnt_i || req_i))
	else begin
		fail_count++;
		$error("Grant given without a request");
	end

	// Waiting result must not move
	a_hold_r: assert property (@(posedge clk) disable iff (!rst_n)
		req_r && !gnt_r |=> req_r && $stable(result_r))
	else begin
		fail_count++;
		$error("R result changed before its grant");
	end

	a_hold_i: assert property (@(posedge clk) disable iff (!rst_n)
		req_i && !gnt_i |=> req_i && $stable(result_i))
	else begin
		fail_count++;
		$error("I result changed before its grant");
	end

	a_turn_r: assert property (@(posedge clk) disable iff (!rst_n) gnt_i ##1 req_r |-> gnt_r)
	else begin
		fail_count++;
		$error("R request lost after an I grant");
	end

	a_turn_i: assert property (@(posedge clk) disable iff (!rst_n) gnt_r ##1 req_i |-> gnt_i)
	else begin
		fail_count++;
		$error("I request lost after an R grant");
	end

endmodule : wb_arbiter_asserts

bind wb_arbiter wb_arbiter_asserts u_asserts (.*);

// File: sim/tb_exec_cluster.sv
// ========================================
// Testbench of exec_cluster: credit issuer,
// reference model, compare process, watchdog
// ========================================
module tb_exec_cluster;
	timeunit 1ns;
	timeprecision 1ps;
	import riscv_pkg::*;

	localparam int n_dir_r = 30;
	localparam int n_dir_i = 27;
	localparam int n_rand  = 40;                      // Per unit
	localparam int n_burst = 24;                      // Per unit, both at once
	localparam int n_ops   = n_dir_r + n_dir_i + 2 * n_rand + 2 * n_burst;
	localparam int limit   = 16 + 20 * n_ops + 200;

	// Function codes as {bit 30, funct3}
	localparam logic [3:0] r_codes [10] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
		4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};
	localparam logic [3:0] i_codes [9] = '{4'b0000, 4'b0010, 4'b0011, 4'b0100, 4'b0110,
		4'b0111, 4'b0001, 4'b0101, 4'b1101};

	logic   clk;
	logic   rst_n;
	logic   r_valid;
	r_op_t  r_op;
	logic   r_credit;
	logic   i_valid;
	i_op_t  i_op;
	logic   i_credit;
	logic   wb_valid;
	wb_t    wb;
	integer seed = 32'h243e;
	int     r_spent = 0;
	int     r_returned = 0;
	int     i_spent = 0;
	int     i_returned = 0;
	wb_t    exp_r[$];
	wb_t    exp_i[$];
	string  test_name = "reset";
	logic   last_was_i = 1'b1;                        // R has first priority

	exec_cluster DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.r_valid  (r_valid),
		.r_op     (r_op),
		.r_credit (r_credit),
		.i_valid  (i_valid),
		.i_op     (i_op),
		.i_credit (i_credit),
		.wb_valid (wb_valid),
		.wb       (wb)
	);

	always #5 clk = ~clk;

	function automatic logic [xlen-1:0] shift_right(input logic [xlen-1:0] a,
			input logic [4:0] sh, input logic arith);
		logic [xlen-1:0] fill;
		fill = (arith && a[xlen-1]) ? ~({xlen{1'b1}} >> sh) : '0;
		return (a >> sh) | fill;
	endfunction

	// Expected R result from funct7 bit 30 and funct3
	function automatic logic [xlen-1:0] ref_r(input r_op_t op);
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		a = op.rv1;
		b = op.rv2;
		case (op.idata[14:12])
			3'b000:  return op.idata[30] ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return shift_right(a, b[4:0], op.idata[30]);
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [xlen-1:0] ref_i(input i_op_t op);
		logic [xlen-1:0] a;
		logic [xlen-1:0] imm;
		a   = op.rv1;
		imm = {{20{op.idata[31]}}, op.idata[31:20]};
		case (op.idata[14:12])
			3'b000:  return a + imm;
			3'b001:  return a << op.idata[24:20];
			3'b010:  return ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
			3'b011:  return (a < imm) ? 32'd1 : 32'd0;
			3'b100:  return a ^ imm;
			3'b101:  return shift_right(a, op.idata[24:20], op.idata[30]);
			3'b110:  return a | imm;
			default: return a & imm;
		endcase
	endfunction

	task automatic check_wb(input string name, input wb_t exp, input wb_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected rd %0d data %h, actual rd %0d data %h",
				name, exp.rd, exp.data, act.rd, act.data);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_credit(input string name, input logic [credit_w-1:0] exp,
			input logic [credit_w-1:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Called and returns at 1 ns after a rising edge
	task automatic issue_r(input logic [3:0] code, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		r_op_t      op;
		logic [4:0] rd;
		rd       = 5'(1 + $unsigned($random(seed)) % 15);
		op.idata = {1'b0, code[3], 5'b0, 10'($random(seed)), code[2:0], rd, 7'b0110011};
		op.rv1   = a;
		op.rv2   = b;
		while (queue_depth - r_spent + r_returned == 0) begin
			@(posedge clk);                           // Out of credits
			#1;
		end
		r_valid = 1'b1;
		r_op    = op;
		r_spent++;
		exp_r.push_back('{rd: rd, data: ref_r(op)});
		@(posedge clk);
		#1;
		r_valid = 1'b0;
	endtask

	task automatic issue_i(input logic [3:0] code, input logic [11:0] imm,
			input logic [xlen-1:0] a);
		i_op_t       op;
		logic [4:0]  rd;
		logic [11:0] field;
		rd    = 5'(16 + $unsigned($random(seed)) % 16);
		field = imm;
		if (code[1:0] == 2'b01)
			field = {1'b0, code[3], 5'b0, imm[4:0]};  // Shifts carry funct7
		op.idata = {field, 5'($random(seed)), code[2:0], rd, 7'b0010011};
		op.rv1   = a;
		while (queue_depth - i_spent + i_returned == 0) begin
			@(posedge clk);
			#1;
		end
		i_valid = 1'b1;
		i_op    = op;
		i_spent++;
		exp_i.push_back('{rd: rd, data: ref_i(op)});
		@(posedge clk);
		#1;
		i_valid = 1'b0;
	endtask

	task automatic rand_r();
		int              k;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		k = $unsigned($random(seed)) % 10;
		a = $random(seed);
		b = $random(seed);
		issue_r(r_codes[k], a, b);
	endtask

	task automatic rand_i();
		int              k;
		logic [11:0]     imm;
		logic [xlen-1:0] a;
		k   = $unsigned($random(seed)) % 9;
		imm = 12'($random(seed));
		a   = $random(seed);
		issue_i(i_codes[k], imm, a);
	endtask

	// All writebacks seen and every credit home
	task automatic wait_drain(input string name);
		while (exp_r.size() != 0 || exp_i.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
		#1;
		check_credit({name, " r credits"}, credit_w'(queue_depth),
			credit_w'(queue_depth - r_spent + r_returned));
		check_credit({name, " i credits"}, credit_w'(queue_depth),
			credit_w'(queue_depth - i_spent + i_returned));
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (r_credit)
				r_returned++;
			if (i_credit)
				i_returned++;
		end
	end

	always @(negedge clk) begin : compare
		logic is_i;
		is_i = (wb.rd >= 5'd16);                      // I ops use rd 16 to 31
		if (rst_n && wb_valid) begin
			if (DUT.req_r && DUT.req_i && is_i == last_was_i) begin
				$display("Arbiter granted the same unit twice while both requested, rd %0d",
					wb.rd);
				$display("Testbench failed");
				$fatal(1);
			end else if ((is_i && exp_i.size() == 0) || (!is_i && exp_r.size() == 0)) begin
				$display("Writeback to rd %0d appeared with no op pending", wb.rd);
				$display("Testbench failed");
				$fatal(1);
			end else begin
				last_was_i = is_i;
				if (is_i)
					check_wb(test_name, exp_i.pop_front(), wb);
				else
					check_wb(test_name, exp_r.pop_front(), wb);
			end
		end
	end

	// Stop at the first arbiter assertion failure
	always @(negedge clk) begin
		if (DUT.u_arbiter.u_asserts.fail_count != 0) begin
			$display("An arbiter assertion failed in test %s", test_name);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	initial begin
		repeat (limit) @(posedge clk);
		$display("Run timed out after %0d cycles with writebacks still pending", limit);
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		clk     = 1'b0;
		rst_n   = 1'b0;
		r_valid = 1'b0;
		r_op    = '0;
		i_valid = 1'b0;
		i_op    = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_name = "r_directed";
		for (int k = 0; k < 10; k++) begin
			issue_r(r_codes[k], 32'hFFFF_FFFB, 32'h0000_0003);
			issue_r(r_codes[k], 32'h8000_0000, 32'h0000_0025);  // Shift uses bits 4:0
			issue_r(r_codes[k], 32'h7FFF_FFFF, 32'h8000_0000);
		end
		wait_drain(test_name);

		test_name = "i_directed";
		for (int k = 0; k < 9; k++) begin
			issue_i(i_codes[k], 12'hFFB, 32'h0000_0003);
			issue_i(i_codes[k], 12'h7FF, 32'h8000_00F0);
			issue_i(i_codes[k], 12'h813, 32'hFFFF_F000);
		end
		wait_drain(test_name);

		test_name = "r_random";
		repeat (n_rand) rand_r();
		wait_drain(test_name);

		test_name = "i_random";
		repeat (n_rand) rand_i();
		wait_drain(test_name);

		// Both units saturate the write port
		test_name = "burst_both";
		fork
			repeat (n_burst) rand_r();
			repeat (n_burst) rand_i();
		join
		wait_drain(test_name);

		if (DUT.u_arbiter.u_asserts.fail_count != 0) begin
			$display("Arbiter assertions failed %0d times",
				DUT.u_arbiter.u_asserts.fail_count);
			$display("Testbench failed");
			$fatal(1);
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule : tb_exec_cluster

// File: src.f
design/riscv_pkg.sv
design/op_queue.sv
design/r_type_alu.sv
design/i_type_alu.sv
design/wb_arbiter.sv
design/exec_cluster.sv
sim/exec_cluster_asserts.sv
sim/tb_exec_cluster.sv
